// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_eurorack
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim.f ====
verilog/audio_pkg.sv
verilog/uart_pkg.sv
verilog/codec_tdm_port.sv
verilog/quad_cal.sv
verilog/sample_crusher.sv
verilog/uart_tx.sv
verilog/sample_streamer.sv
verilog/eurorack_top.sv
tb/tb_eurorack.sv

// ==== tb/tb_eurorack.sv ====
// Codec and UART models are behavioural; about 64 frames run, enough for several UART records
`timescale 1ns/1ns

module tb_eurorack;
    import audio_pkg::*;
    import uart_pkg::*;

    localparam int NF = 64;

    logic CLK = 1'b0;
    logic reset;
    logic sdout;
    logic [CRUSH_W-1:0] crush_bits;
    logic bick, lrck, sdin, pdn, tx, led_sample, led_record;

    quad_t adc_frames [NF];
    logic [CRUSH_W-1:0] crush_tab [NF];
    quad_t cur_adc;
    logic [63:0] dac_bits;
    logic lrck_q, bick_q;
    int pos, fidx, cap_cnt, errors, recs, seed, n, seg_err;

    eurorack_top UUT (
        .CLK(CLK), .reset(reset), .sdout(sdout), .bick(bick), .lrck(lrck), .sdin(sdin),
        .pdn(pdn), .tx(tx), .led_sample(led_sample), .led_record(led_record),
        .crush_bits(crush_bits)
    );

    always #20 CLK = ~CLK;

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Gain in Q2.14 with floor, then offset, then clamp to 16 bits
    function automatic sample_t scale(input sample_t x, input cal_coef_t c);
        longint v;
        v = (longint'(x) * longint'(c.gain)) >>> 14;
        v = v + longint'(c.offset);
        if (v > 32767) v = 32767;
        if (v < -32768) v = -32768;
        return sample_t'(v);
    endfunction

    function automatic sample_t in_ref(input quad_t adc, input int ch);
        sample_t raw;
        raw = adc[63 - 16*ch -: 16];
        return scale(~raw, IN_CAL[ch]);
    endfunction

    function automatic sample_t dac_ref(input quad_t adc, input logic [3:0] cb, input int ch);
        sample_t v;
        v = in_ref(adc, ch);
        v = v & ~sample_t'((32'd1 << cb) - 1);
        return scale(v, OUT_CAL[ch]);
    endfunction

    // Codec model, follows lrck and bick from the DUT
    always @(negedge CLK) begin
        if (pdn === 1'b1 && lrck && !lrck_q) begin
            if (fidx >= 1 && fidx < NF) begin
                for (int c = 0; c < NUM_CH; c++) begin
                    check_val($sformatf("sdin ch%0d frame %0d", c, fidx),
                              dac_bits[63 - 16*c -: 16],
                              $unsigned(dac_ref(adc_frames[fidx-1], crush_tab[fidx-1], c)));
                end
            end
            fidx++;
            pos = 0;
            dac_bits = '0;
            cur_adc = (fidx < NF) ? adc_frames[fidx] : '0;
            if (fidx < NF) crush_bits = crush_tab[fidx];
        end else if (pdn === 1'b1 && bick_q && !bick) begin
            pos++;
        end
        if (pdn === 1'b1 && bick && !bick_q) begin
            if (pos % 32 < 16) dac_bits = {dac_bits[62:0], sdin};
            if (pos == 111) cap_cnt = fidx;
        end
        sdout = (pos % 32 < 16) ? cur_adc[63 - (pos/32)*16 - pos%32] : 1'b0;
        lrck_q = lrck;
        bick_q = bick;
    end

    // UART receiver, samples at mid-bit and checks each record
    initial begin : uart_rx
        logic [7:0] b;
        logic [15:0] word;
        int cand, bi, t;
        bi = 0;
        forever begin
            t = 0;
            while (tx !== 1'b0 && t < 40000) begin
                @(negedge CLK);
                t++;
            end
            if (t >= 40000) begin
                $display("No UART start bit within 40000 clocks");
                errors++;
            end
            if (bi == 2) cand = cap_cnt;
            if (bi == 3) begin
                check_val("led_sample", led_sample, (recs + 1) % 2);
                check_val("led_record", led_record, recs % 2);
            end
            repeat (CLKS_PER_BIT / 2) @(negedge CLK);
            check_val("tx start bit", tx, 0);
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge CLK);
                b[i] = tx;
            end
            repeat (CLKS_PER_BIT) @(negedge CLK);
            check_val("tx stop bit", tx, 1);
            case (bi)
                0: check_val("uart byte C", b, 8'h43);
                1: check_val("uart byte H", b, 8'h48);
                2: check_val("uart channel", b, 8'h30 + recs % 4);
                3: word[15:8] = b;
                default: begin
                    word[7:0] = b;
                    // Frame boundary may fall right at the ID byte, so two frames qualify
                    assert (cand + 1 >= NF || word === in_ref(adc_frames[cand], recs % 4) ||
                            word === in_ref(adc_frames[cand + 1], recs % 4)) else begin
                        $display("[FAIL] uart sample got %h expected %h or %h", word,
                                 in_ref(adc_frames[cand], recs % 4),
                                 in_ref(adc_frames[cand + 1], recs % 4));
                        errors++;
                    end
                    recs++;
                end
            endcase
            bi = (bi + 1) % 5;
        end
    end

    task automatic wait_frame(input int last, input string name);
        n = 0;
        seg_err = errors;
        while (fidx < last && n < 600 * NF) begin
            @(negedge CLK);
            n++;
        end
        if (fidx < last) begin
            $display("Timeout waiting for frame %0d", last);
            errors++;
        end
        $display("%s: %0d errors", name, errors - seg_err);
    endtask

    initial begin
        seed = 53018;
        reset = 1'b1;
        sdout = 1'b0;
        crush_bits = '0;
        fidx = -1;
        pos = 0;
        cap_cnt = 0;
        errors = 0;
        recs = 0;
        lrck_q = 1'b0;
        bick_q = 1'b0;
        cur_adc = '0;
        for (int f = 0; f < NF; f++) begin
            adc_frames[f] = {16'($random(seed)), 16'($random(seed)),
                             16'($random(seed)), 16'($random(seed))};
            crush_tab[f] = (f >= 20 && f < 40) ? 4'($random(seed)) : 4'd0;
            // Full scale both ways
            if (f >= 40 && f < 48) adc_frames[f] = {16'h8000, 16'h7FFF, 16'h8000, 16'h7FFF};
        end
        repeat (4) @(negedge CLK);
        reset = 1'b0;
        check_val("tx", tx, 1);
        check_val("pdn", pdn, 0);
        check_val("lrck", lrck, 0);
        check_val("leds", {led_sample, led_record}, 0);
        n = 0;
        while (pdn !== 1'b1 && n < 1000) begin
            @(negedge CLK);
            n++;
        end
        check_val("pdn rise clocks", n, PDN_HOLD);
        $display("reset state: %0d errors", errors);
        wait_frame(21, "audio path");
        wait_frame(41, "crush depth");
        wait_frame(49, "saturation");
        wait_frame(NF, "mixed frames");
        if (recs < 4) begin
            $display("Only %0d UART records received", recs);
            errors++;
        end
        $display("uart records and leds: %0d records", recs);
        $display("tests 6, errors %0d", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog/audio_pkg.sv ====
// Sample format and calibration tables are fixed at build time; gains are Q2.14 so |gain| < 2
package audio_pkg;

    typedef logic signed [15:0] sample_t;

    // One frame of all four channels, ch0 in the top bits
    typedef struct packed {
        sample_t ch0;
        sample_t ch1;
        sample_t ch2;
        sample_t ch3;
    } quad_t;

    localparam int NUM_CH     = 4;
    localparam int CH_W       = $clog2(NUM_CH);
    localparam int SLOT_BITS  = 32;
    localparam int BICK_DIV   = 4;
    localparam int FRAME_CLKS = 512;
    localparam int PDN_HOLD   = 64;
    localparam int CRUSH_W    = 4;

    localparam sample_t SMP_MAX = 16'sh7FFF;
    localparam sample_t SMP_MIN = 16'sh8000;

    // Gain is Q2.14, 16384 is unity
    typedef struct packed {
        logic signed [15:0] gain;
        logic signed [15:0] offset;
    } cal_coef_t;

    localparam int GAIN_FRAC = 14;
    localparam int CAL_IN    = 0;
    localparam int CAL_OUT   = 1;

    // Measured per channel on the bench
    localparam cal_coef_t IN_CAL [NUM_CH] = '{
        '{gain: 16'sd17039, offset: -16'sd184},
        '{gain: 16'sd16876, offset: 16'sd96},
        '{gain: 16'sd17203, offset: -16'sd57},
        '{gain: 16'sd16712, offset: 16'sd230}
    };

    localparam cal_coef_t OUT_CAL [NUM_CH] = '{
        '{gain: 16'sd15729, offset: 16'sd410},
        '{gain: 16'sd16876, offset: -16'sd350},
        '{gain: 16'sd16220, offset: 16'sd275},
        '{gain: 16'sd17039, offset: -16'sd128}
    };

endpackage

// ==== verilog/codec_tdm_port.sv ====
// Codec must be set up for TDM128 slave mode; BICK_DIV and the slot count must be powers of two
`timescale 1ns/1ns

module codec_tdm_port (
    input  logic             CLK,
    input  logic             reset,
    input  logic             sdout,
    output logic             bick,
    output logic             lrck,
    output logic             sdin,
    output logic             pdn,
    output audio_pkg::quad_t adc_quad,
    input  audio_pkg::quad_t dac_quad,
    output logic             frame_strobe
);
    import audio_pkg::*;

    localparam int BITS_PER_FRAME = FRAME_CLKS / BICK_DIV;
    localparam int POS_W          = $clog2(BITS_PER_FRAME);
    localparam int PRE_W          = $clog2(BICK_DIV);
    localparam int SLOT_W         = $clog2(SLOT_BITS);
    localparam int SMP_W          = $bits(sample_t);
    localparam int QUAD_W         = $bits(quad_t);
    localparam int HOLD_W         = $clog2(PDN_HOLD);
    localparam int LAST_ADC_POS   = (NUM_CH - 1) * SLOT_BITS + SMP_W - 1;

    logic [HOLD_W-1:0] hold_cnt;
    logic [PRE_W-1:0]  pre_cnt;
    logic [POS_W-1:0]  bit_pos;
    logic              rise_tick;
    logic              fall_tick;
    logic              data_bit;
    logic [QUAD_W-1:0] adc_sr;
    logic [QUAD_W-1:0] adc_next;
    logic [QUAD_W-1:0] dac_sr;

    // Hold the codec in power-down for a while after reset
    always_ff @(posedge CLK) begin
        if (reset) begin
            hold_cnt <= '0;
            pdn      <= 1'b0;
        end else if (!pdn) begin
            hold_cnt <= hold_cnt + 1'b1;
            if (hold_cnt == HOLD_W'(PDN_HOLD - 1)) begin
                pdn <= 1'b1;
            end
        end
    end

    // Bit clock prescaler and frame position, both wrap on their own
    always_ff @(posedge CLK) begin
        if (reset) begin
            pre_cnt <= '0;
            bit_pos <= '0;
        end else if (pdn) begin
            pre_cnt <= pre_cnt + 1'b1;
            if (fall_tick) begin
                bit_pos <= bit_pos + 1'b1;
            end
        end
    end

    // Clock edge where bick rises, and the one where it falls
    assign rise_tick = pdn && (pre_cnt == PRE_W'(BICK_DIV / 2 - 1));
    assign fall_tick = pdn && (pre_cnt == PRE_W'(BICK_DIV - 1));

    // Sample sits in the first 16 bits of each slot
    assign data_bit = (bit_pos[SLOT_W-1:0] < SLOT_W'(SMP_W));

    assign bick = pre_cnt[PRE_W-1];
    assign lrck = pdn && (bit_pos == '0);
    assign sdin = pdn && data_bit && dac_sr[QUAD_W-1];

    assign adc_next = {adc_sr[QUAD_W-2:0], sdout};

    // ADC slots shift in MSB first, ch0 ends up on top
    always_ff @(posedge CLK) begin
        if (rise_tick && data_bit) begin
            adc_sr <= adc_next;
        end
        if (rise_tick && (bit_pos == POS_W'(LAST_ADC_POS))) begin
            adc_quad <= quad_t'(adc_next);
        end
    end

    // Strobe lands in slot 3 right after its last data bit
    always_ff @(posedge CLK) begin
        if (reset) begin
            frame_strobe <= 1'b0;
        end else begin
            frame_strobe <= rise_tick && (bit_pos == POS_W'(LAST_ADC_POS));
        end
    end

    // DAC quad is taken at the frame boundary, long after the pipeline has settled
    always_ff @(posedge CLK) begin
        if (reset) begin
            dac_sr <= '0;
        end else if (fall_tick && (bit_pos == '1)) begin
            dac_sr <= dac_quad;
        end else if (fall_tick && data_bit) begin
            dac_sr <= dac_sr << 1;
        end
    end

    a_strobe_single: assert property (@(posedge CLK) disable iff (reset)
        frame_strobe |=> !frame_strobe)
        else $error("frame_strobe high on two consecutive clocks");

endmodule

// ==== verilog/eurorack_top.sv ====
// Analog front end inverts the inputs; the one's complement here is off by one LSB
`timescale 1ns/1ns

module eurorack_top (
    input  logic                          CLK,
    input  logic                          reset,
    input  logic                          sdout,
    output logic                          bick,
    output logic                          lrck,
    output logic                          sdin,
    output logic                          pdn,
    output logic                          tx,
    output logic                          led_sample,
    output logic                          led_record,
    input  logic [audio_pkg::CRUSH_W-1:0] crush_bits
);
    import audio_pkg::*;

    quad_t      adc_quad;
    quad_t      inv_quad;
    quad_t      in_cal_quad;
    quad_t      crush_quad;
    quad_t      dac_quad;
    logic       frame_strobe;
    logic       in_valid;
    logic       crush_valid;
    logic       tx_start;
    logic       busy;
    logic [7:0] tx_data;

    codec_tdm_port codec (
        .CLK(CLK), .reset(reset), .sdout(sdout), .bick(bick), .lrck(lrck), .sdin(sdin),
        .pdn(pdn), .adc_quad(adc_quad), .dac_quad(dac_quad), .frame_strobe(frame_strobe)
    );

    // Back to true polarity
    assign inv_quad = ~adc_quad;

    quad_cal #(.CAL_SET(CAL_IN)) in_cal (
        .CLK(CLK), .reset(reset), .in_quad(inv_quad), .in_strobe(frame_strobe),
        .out_quad(in_cal_quad), .out_strobe(in_valid)
    );

    sample_crusher crusher (
        .CLK(CLK), .reset(reset), .in_quad(in_cal_quad), .in_strobe(in_valid),
        .crush_bits(crush_bits), .out_quad(crush_quad), .out_strobe(crush_valid)
    );

    // Codec picks dac_quad up at the frame boundary, no strobe needed
    quad_cal #(.CAL_SET(CAL_OUT)) out_cal (
        .CLK(CLK), .reset(reset), .in_quad(crush_quad), .in_strobe(crush_valid),
        .out_quad(dac_quad), .out_strobe()
    );

    sample_streamer streamer (
        .CLK(CLK), .reset(reset), .in_quad(in_cal_quad), .in_strobe(in_valid), .busy(busy),
        .tx_start(tx_start), .tx_data(tx_data), .led_sample(led_sample),
        .led_record(led_record)
    );

    uart_tx uart (
        .CLK(CLK), .reset(reset), .tx_start(tx_start), .tx_data(tx_data), .tx(tx), .busy(busy)
    );

endmodule

// ==== verilog/quad_cal.sv ====
// Coefficients are fixed per build; results outside the 16-bit range clamp to full scale
`timescale 1ns/1ns

module quad_cal #(
    parameter int CAL_SET = audio_pkg::CAL_IN
) (
    input  logic             CLK,
    input  logic             reset,
    input  audio_pkg::quad_t in_quad,
    input  logic             in_strobe,
    output audio_pkg::quad_t out_quad,
    output logic             out_strobe
);
    import audio_pkg::*;

    function automatic cal_coef_t coef(input int ch);
        if (CAL_SET == CAL_OUT) begin
            return OUT_CAL[ch];
        end
        return IN_CAL[ch];
    endfunction

    // Scale by Q2.14 gain, add offset, clamp
    function automatic sample_t apply_cal(input sample_t smp, input cal_coef_t c);
        logic signed [31:0] prod;
        logic signed [31:0] sum;
        prod = smp * c.gain;
        sum  = (prod >>> GAIN_FRAC) + c.offset;
        if (sum > SMP_MAX) begin
            return SMP_MAX;
        end
        if (sum < SMP_MIN) begin
            return SMP_MIN;
        end
        return sample_t'(sum);
    endfunction

    always_ff @(posedge CLK) begin
        if (in_strobe) begin
            out_quad.ch0 <= apply_cal(in_quad.ch0, coef(0));
            out_quad.ch1 <= apply_cal(in_quad.ch1, coef(1));
            out_quad.ch2 <= apply_cal(in_quad.ch2, coef(2));
            out_quad.ch3 <= apply_cal(in_quad.ch3, coef(3));
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            out_strobe <= 1'b0;
        end else begin
            out_strobe <= in_strobe;
        end
    end

    // Downstream stages count on a single-clock strobe and a fixed one-clock step
    a_strobe_step: assert property (@(posedge CLK) disable iff (reset)
        in_strobe |=> out_strobe && !in_strobe)
        else $error("in_strobe not a single pulse one clock ahead of out_strobe");

endmodule

// ==== verilog/sample_crusher.sv ====
// Depth is taken with each strobe; 0 passes samples through, 15 leaves only the sign bit
`timescale 1ns/1ns

module sample_crusher (
    input  logic                              CLK,
    input  logic                              reset,
    input  audio_pkg::quad_t                  in_quad,
    input  logic                              in_strobe,
    input  logic [audio_pkg::CRUSH_W-1:0]     crush_bits,
    output audio_pkg::quad_t                  out_quad,
    output logic                              out_strobe
);
    import audio_pkg::*;

    sample_t keep_mask;

    // Clearing low bits rounds toward minus infinity
    assign keep_mask = SMP_MIN >>> (CRUSH_W'($bits(sample_t) - 1) - crush_bits);

    always_ff @(posedge CLK) begin
        if (in_strobe) begin
            out_quad.ch0 <= in_quad.ch0 & keep_mask;
            out_quad.ch1 <= in_quad.ch1 & keep_mask;
            out_quad.ch2 <= in_quad.ch2 & keep_mask;
            out_quad.ch3 <= in_quad.ch3 & keep_mask;
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            out_strobe <= 1'b0;
        end else begin
            out_strobe <= in_strobe;
        end
    end

endmodule

// ==== verilog/sample_streamer.sv ====
// One channel per record in rotation; sample is taken from the first frame after the ID byte
`timescale 1ns/1ns

module sample_streamer (
    input  logic             CLK,
    input  logic             reset,
    input  audio_pkg::quad_t in_quad,
    input  logic             in_strobe,
    input  logic             busy,
    output logic             tx_start,
    output logic [7:0]       tx_data,
    output logic             led_sample,
    output logic             led_record
);
    import audio_pkg::*;
    import uart_pkg::*;

    rec_state_t      state;
    logic [CH_W-1:0] ch;
    logic            id_sent;
    sample_t         word;
    logic [7:0]      next_byte;
    logic            send_now;

    // tx_start is still high on the clock before busy rises
    assign send_now = !busy && !tx_start && !(state == S_ID && id_sent);

    always_comb begin
        case (state)
            S_H:     next_byte = "H";
            S_ID:    next_byte = "0" + 8'(ch);
            S_MSB:   next_byte = word[15:8];
            S_LSB:   next_byte = word[7:0];
            default: next_byte = "C";
        endcase
    end

    always_ff @(posedge CLK) begin
        if (send_now) begin
            tx_data <= next_byte;
        end
    end

    always_ff @(posedge CLK) begin
        if (state == S_ID && id_sent && in_strobe) begin
            case (ch)
                2'd0:    word <= in_quad.ch0;
                2'd1:    word <= in_quad.ch1;
                2'd2:    word <= in_quad.ch2;
                default: word <= in_quad.ch3;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            state      <= S_C;
            ch         <= '0;
            id_sent    <= 1'b0;
            tx_start   <= 1'b0;
            led_sample <= 1'b0;
            led_record <= 1'b0;
        end else begin
            tx_start <= send_now;
            case (state)
                S_C:   state <= send_now ? S_H : S_C;
                S_H:   state <= send_now ? S_ID : S_H;
                S_ID: begin
                    if (send_now) begin
                        id_sent <= 1'b1;
                    end else if (id_sent && in_strobe) begin
                        // Sample captured, MSB goes out next
                        id_sent    <= 1'b0;
                        led_sample <= ~led_sample;
                        state      <= S_MSB;
                    end
                end
                S_MSB: state <= send_now ? S_LSB : S_MSB;
                S_LSB: begin
                    if (send_now) begin
                        ch         <= ch + 1'b1;
                        led_record <= ~led_record;
                        state      <= S_C;
                    end
                end
                default: state <= S_C;
            endcase
        end
    end

endmodule

// ==== verilog/uart_pkg.sv ====
// Bit timing assumes a 12 MHz system clock; the integer divide leaves about 0.2% baud error
package uart_pkg;

    localparam int CLK_HZ       = 12_000_000;
    localparam int BAUD         = 115_200;
    localparam int CLKS_PER_BIT = CLK_HZ / BAUD;
    localparam int BAUD_W       = $clog2(CLKS_PER_BIT);

    // Start, eight data bits and stop
    localparam int FRAME_BITS = 10;
    localparam int BIT_IDX_W  = $clog2(FRAME_BITS);

    // Record is "C", "H", channel digit, MSB, LSB
    typedef enum logic [2:0] {
        S_C,
        S_H,
        S_ID,
        S_MSB,
        S_LSB
    } rec_state_t;

endpackage

// ==== verilog/uart_tx.sv ====
// 8N1 only, no parity; caller must wait for busy low before pulsing tx_start
`timescale 1ns/1ns

module uart_tx (
    input  logic       CLK,
    input  logic       reset,
    input  logic       tx_start,
    input  logic [7:0] tx_data,
    output logic       tx,
    output logic       busy
);
    import uart_pkg::*;

    logic [BAUD_W-1:0]    baud_cnt;
    logic [BIT_IDX_W-1:0] bit_idx;
    // Data bits then the stop bit, shifted out LSB first
    logic [8:0]           shifter;

    always_ff @(posedge CLK) begin
        if (reset) begin
            tx       <= 1'b1;
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_idx  <= '0;
        end else if (!busy) begin
            if (tx_start) begin
                // Start bit goes out right away
                tx       <= 1'b0;
                busy     <= 1'b1;
                baud_cnt <= '0;
                bit_idx  <= '0;
            end
        end else if (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1)) begin
            baud_cnt <= '0;
            if (bit_idx == BIT_IDX_W'(FRAME_BITS - 1)) begin
                busy <= 1'b0;
            end else begin
                tx      <= shifter[0];
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (!busy && tx_start) begin
            shifter <= {1'b1, tx_data};
        end else if (busy && (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1))) begin
            shifter <= shifter >> 1;
        end
    end

    // The streamer must honour busy, a start now would be dropped
    a_no_start_busy: assert property (@(posedge CLK) disable iff (reset)
        busy |-> !tx_start)
        else $error("tx_start while uart_tx busy");

endmodule
